/* csma_ca.f */
logic/csma_pkg.sv
logic/nav_tracker.sv
logic/backoff_rng.sv
logic/backoff_fsm.sv
logic/csma_ca.sv
testbench/csma_ca_tb.sv

/* logic/backoff_fsm.sv */
// channel access FSM with IFS selection, IFS wait timer and slot backoff timer
`timescale 1ns/10ps

module backoff_fsm import csma_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  us_tick,
    input  logic                  medium_idle,
    input  ifs_cfg_t              ifs,
    input  logic                  rx_fcs_strobe,
    input  logic                  rx_fcs_valid,
    input  logic                  high_trigger,
    input  logic                  retrans_trigger,
    input  logic                  tx_bb_is_ongoing,
    input  logic [SLOT_CNT_W-1:0] num_slots,
    output logic                  draw,
    output logic                  backoff_done,
    output logic                  increase_cw,
    output logic [SLOT_CNT_W-1:0] num_slot_log
);

    backoff_state_t  state;
    logic [US_W-1:0] difs_us;
    logic [US_W-1:0] eifs_us;
    logic [US_W-1:0] ifs_us;
    logic [US_W-1:0] wait_timer;
    logic [BO_W-1:0] bo_timer;
    logic            prev_fcs_good;
    logic            is_retx;    // current attempt needs a backoff
    logic            bo_load;    // first RUN cycle, lfsr has just stepped

    assign difs_us = ifs.difs_enable ?
                     US_W'(ifs.sifs_time) + US_W'({ifs.slot_time, 1'b0}) : '0;
    assign eifs_us = ifs.eifs_enable ?
                     US_W'(ifs.sifs_time) + difs_us + LONGEST_ACK_US : '0;

    // EIFS after a corrupted frame, also right after reset
    assign ifs_us = prev_fcs_good ? difs_us : eifs_us;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prev_fcs_good <= 1'b0;
        end else if (rx_fcs_strobe) begin
            prev_fcs_good <= rx_fcs_valid;
        end
    end

    // step the rng as the retransmission IFS wait ends
    assign draw = (state == BO_WAIT_RETX) && medium_idle && (wait_timer == '0);

    assign backoff_done = (state == BO_GRANTED);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= BO_IDLE;
            wait_timer   <= '0;
            bo_timer     <= '0;
            is_retx      <= 1'b0;
            bo_load      <= 1'b0;
            increase_cw  <= 1'b0;
            num_slot_log <= '0;
        end else begin
            increase_cw <= 1'b0;    // single cycle pulse
            bo_load     <= 1'b0;
            case (state)
                BO_IDLE: begin
                    if (high_trigger || retrans_trigger) begin
                        is_retx <= !high_trigger;    // new frame wins a tie
                        if (high_trigger) begin
                            num_slot_log <= '0;
                        end
                        if (medium_idle) begin
                            wait_timer <= ifs_us;
                            state      <= high_trigger ? BO_WAIT_NEW : BO_WAIT_RETX;
                        end else begin
                            increase_cw <= !high_trigger;
                            state       <= BO_CH_BUSY;
                        end
                    end
                end
                BO_CH_BUSY: begin
                    if (medium_idle) begin
                        wait_timer <= ifs_us;    // full IFS again after busy
                        state      <= is_retx ? BO_WAIT_RETX : BO_WAIT_NEW;
                    end
                end
                BO_WAIT_NEW: begin
                    if (!medium_idle) begin
                        state <= BO_CH_BUSY;
                    end else if (wait_timer == '0) begin
                        state <= BO_GRANTED;
                    end else if (us_tick) begin
                        wait_timer <= wait_timer - 1'b1;
                    end
                end
                BO_WAIT_RETX: begin
                    if (!medium_idle) begin
                        increase_cw <= 1'b1;
                        state       <= BO_CH_BUSY;
                    end else if (wait_timer == '0) begin
                        bo_load <= 1'b1;
                        state   <= BO_RUN;
                    end else if (us_tick) begin
                        wait_timer <= wait_timer - 1'b1;
                    end
                end
                BO_RUN: begin
                    if (bo_load) begin
                        bo_timer     <= BO_W'(num_slots) * BO_W'(ifs.slot_time);
                        num_slot_log <= num_slots;
                    end else if (!medium_idle) begin
                        state <= BO_SUSPEND;    // countdown frozen
                    end else if (bo_timer == '0) begin
                        state <= BO_GRANTED;
                    end else if (us_tick) begin
                        bo_timer <= bo_timer - 1'b1;
                    end
                end
                BO_SUSPEND: begin
                    if (medium_idle) begin
                        state <= BO_RUN;
                    end
                end
                BO_GRANTED: begin
                    // grant held until the baseband starts sending
                    if (tx_bb_is_ongoing) begin
                        state <= BO_IDLE;
                    end
                end
                default: state <= BO_IDLE;
            endcase
        end
    end

endmodule

/* logic/backoff_rng.sv */
// backoff random source with XNOR LFSR and contention window masking
`timescale 1ns/10ps

module backoff_rng import csma_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  draw,
    input  logic [3:0]            cw_exp_used,
    output logic [SLOT_CNT_W-1:0] num_slots
);

    logic [31:0]           lfsr;
    logic                  feedback;
    logic [3:0]            exp_clamped;
    logic [SLOT_CNT_W-1:0] win_mask;

    // taps 31, 21, 1, 0
    assign feedback = ~^{lfsr[31], lfsr[21], lfsr[1:0]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lfsr <= LFSR_RESET;
        end else if (draw) begin
            lfsr <= {lfsr[30:0], feedback};
        end
    end

    assign exp_clamped = (cw_exp_used > CW_EXP_MAX) ? CW_EXP_MAX : cw_exp_used;

    // 2^exp - 1, all ones at the largest exponent
    assign win_mask = ~({SLOT_CNT_W{1'b1}} << exp_clamped);

    assign num_slots = lfsr[SLOT_CNT_W-1:0] & win_mask;

endmodule

/* logic/csma_ca.sv */
// CSMA/CA channel access top with NAV tracker, backoff rng, access FSM and medium idle
`timescale 1ns/10ps

module csma_ca import csma_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  rx_frame_t             rx,
    input  logic [47:0]           self_mac_addr,
    input  logic                  nav_enable,
    input  ifs_cfg_t              ifs,
    input  logic [3:0]            cw_exp_used,
    input  logic                  us_tick,
    input  logic                  ch_idle,
    input  logic                  high_trigger,
    input  logic                  retrans_trigger,
    input  logic                  tx_bb_is_ongoing,
    output logic                  backoff_done,
    output logic                  increase_cw,
    output logic [SLOT_CNT_W-1:0] num_slot_log
);

    logic [NAV_W-1:0]      nav;
    logic                  medium_idle;
    logic                  draw;
    logic [SLOT_CNT_W-1:0] num_slots;

    // virtual carrier sense counts only when enabled
    assign medium_idle = ch_idle && (!nav_enable || nav == '0);

    nav_tracker nav_i (
        .clk           (clk),
        .rstn          (rstn),
        .rx            (rx),
        .self_mac_addr (self_mac_addr),
        .us_tick       (us_tick),
        .nav           (nav)
    );

    backoff_rng rng_i (
        .clk         (clk),
        .rstn        (rstn),
        .draw        (draw),
        .cw_exp_used (cw_exp_used),
        .num_slots   (num_slots)
    );

    backoff_fsm fsm_i (
        .clk              (clk),
        .rstn             (rstn),
        .us_tick          (us_tick),
        .medium_idle      (medium_idle),
        .ifs              (ifs),
        .rx_fcs_strobe    (rx.fcs_strobe),
        .rx_fcs_valid     (rx.fcs_valid),
        .high_trigger     (high_trigger),
        .retrans_trigger  (retrans_trigger),
        .tx_bb_is_ongoing (tx_bb_is_ongoing),
        .num_slots        (num_slots),
        .draw             (draw),
        .backoff_done     (backoff_done),
        .increase_cw      (increase_cw),
        .num_slot_log     (num_slot_log)
    );

endmodule

/* logic/csma_pkg.sv */
// widths, protocol constants, state encodings and port structs for the CSMA/CA block
package csma_pkg;

    localparam int US_W       = 12;    // microsecond wait timer
    localparam int NAV_W      = 15;
    localparam int SLOT_CNT_W = 10;
    localparam int BO_W       = SLOT_CNT_W + 5;    // slots times a 5 bit slot time

    localparam logic [3:0]      CW_EXP_MAX     = 4'd10;
    localparam logic [US_W-1:0] LONGEST_ACK_US = 12'd44;
    localparam logic [31:0]     LFSR_RESET     = 32'h1020f0cb;

    // interframe timing configuration, all in microseconds
    typedef struct packed {
        logic [6:0] sifs_time;
        logic [4:0] slot_time;
        logic       difs_enable;
        logic       eifs_enable;
    } ifs_cfg_t;

    // fields reported by the receive path while a frame comes in
    typedef struct packed {
        logic        hdr_strobe;
        logic        hdr_valid;
        logic        fc_di_valid;    // frame control and duration present
        logic [15:0] duration;
        logic        addr1_valid;
        logic [47:0] addr1;
        logic        fcs_strobe;
        logic        fcs_valid;
    } rx_frame_t;

    typedef enum logic [1:0] {
        NAV_IDLE,
        NAV_WAIT_DURATION,
        NAV_CHECK_RA,
        NAV_UPDATE
    } nav_state_t;

    typedef enum logic [2:0] {
        BO_IDLE,
        BO_CH_BUSY,
        BO_WAIT_NEW,     // ifs wait, new frame
        BO_WAIT_RETX,    // ifs wait, retransmission
        BO_RUN,
        BO_SUSPEND,
        BO_GRANTED
    } backoff_state_t;

endpackage

/* logic/nav_tracker.sv */
// network allocation vector tracker with frame state machine and microsecond countdown
`timescale 1ns/10ps

module nav_tracker import csma_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  rx_frame_t        rx,
    input  logic [47:0]      self_mac_addr,
    input  logic             us_tick,
    output logic [NAV_W-1:0] nav
);

    nav_state_t       state;
    logic             nav_set;
    logic [NAV_W-1:0] nav_new;

    // frame walk, a header strobe always restarts it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= NAV_IDLE;
            nav_set <= 1'b0;
        end else begin
            nav_set <= 1'b0;
            if (rx.hdr_strobe) begin
                state <= rx.hdr_valid ? NAV_WAIT_DURATION : NAV_IDLE;
            end else begin
                case (state)
                    NAV_WAIT_DURATION: begin
                        // bit 15 set means AID or reserved, not a duration
                        if (rx.fc_di_valid && !rx.duration[15]) begin
                            state <= NAV_CHECK_RA;
                        end
                    end
                    NAV_CHECK_RA: begin
                        if (rx.addr1_valid) begin
                            // frames for us never touch the NAV
                            state <= (rx.addr1 != self_mac_addr) ? NAV_UPDATE : NAV_IDLE;
                        end
                    end
                    NAV_UPDATE: begin
                        if (rx.fcs_strobe) begin
                            nav_set <= rx.fcs_valid;    // commit only on good fcs
                            state   <= NAV_IDLE;
                        end
                    end
                    default: state <= NAV_IDLE;
                endcase
            end
        end
    end

    // duration held until the fcs decides
    always_ff @(posedge clk) begin
        if (state == NAV_WAIT_DURATION && rx.fc_di_valid) begin
            nav_new <= rx.duration[NAV_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            nav <= '0;
        end else if (nav_set) begin
            nav <= (nav_new > nav) ? nav_new : nav;    // never shorten a running NAV
        end else if (us_tick && nav != '0) begin
            nav <= nav - 1'b1;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# compile the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module csma_ca_tb -f csma_ca.f -o csma_ca_sim

output=$(./obj_dir/csma_ca_sim)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

/* testbench/csma_ca_tb.sv */
// testbench for the CSMA/CA top with xorshift stimulus, timing model and checks
`timescale 1ns/10ps

module csma_ca_tb import csma_pkg::*; ();

    localparam int MAX_CYCLES = 20000;    // the tests take about 11k cycles

    logic                  clk;
    logic                  rstn;
    rx_frame_t             rx;
    logic [47:0]           self_mac_addr;
    logic                  nav_enable;
    ifs_cfg_t              ifs;
    logic [3:0]            cw_exp_used;
    logic                  us_tick;
    logic                  ch_idle;
    logic                  high_trigger;
    logic                  retrans_trigger;
    logic                  tx_bb_is_ongoing;
    logic                  backoff_done;
    logic                  increase_cw;
    logic [SLOT_CNT_W-1:0] num_slot_log;

    logic [1:0]  tick_div;
    logic [31:0] rng_state;
    logic [31:0] model_lfsr;
    logic        model_fcs_good;
    int          sifs_us;
    int          slot_us;
    int          checks;
    int          errors;
    int          checks_mark;
    int          errors_mark;
    int          cycle_count;

    csma_ca UUT (
        .clk              (clk),
        .rstn             (rstn),
        .rx               (rx),
        .self_mac_addr    (self_mac_addr),
        .nav_enable       (nav_enable),
        .ifs              (ifs),
        .cw_exp_used      (cw_exp_used),
        .us_tick          (us_tick),
        .ch_idle          (ch_idle),
        .high_trigger     (high_trigger),
        .retrans_trigger  (retrans_trigger),
        .tx_bb_is_ongoing (tx_bb_is_ongoing),
        .backoff_done     (backoff_done),
        .increase_cw      (increase_cw),
        .num_slot_log     (num_slot_log)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one microsecond tick every fourth cycle
    initial begin
        us_tick  = 1'b0;
        tick_div = 2'd0;
        forever begin
            @(posedge clk);
            tick_div <= tick_div + 2'd1;
            us_tick  <= (tick_div == 2'd3);
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // xnor feedback from bits 31, 21, 1 and 0 enters at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] v);
        logic fb;
        fb = ~(v[31] ^ v[21] ^ v[1] ^ v[0]);
        return {v[30:0], fb};
    endfunction

    function automatic int slots_for(input logic [31:0] v, input int exp_used);
        int e;
        e = (exp_used > 10) ? 10 : exp_used;
        return int'(v[9:0]) & ((1 << e) - 1);
    endfunction

    // DIFS after a good fcs and EIFS otherwise
    function automatic int model_ifs();
        int difs;
        difs = sifs_us + 2 * slot_us;
        return model_fcs_good ? difs : sifs_us + difs + int'(LONGEST_ACK_US);
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    task automatic new_timing();
        sifs_us = 1 + next_rand() % 16;
        slot_us = 1 + next_rand() % 9;
        ifs.sifs_time   <= 7'(sifs_us);
        ifs.slot_time   <= 5'(slot_us);
        ifs.difs_enable <= 1'b1;
        ifs.eifs_enable <= 1'b1;
    endtask

    task automatic pulse_fcs(input logic valid);
        @(posedge clk);
        rx.fcs_strobe <= 1'b1;
        rx.fcs_valid  <= valid;
        @(posedge clk);
        rx.fcs_strobe <= 1'b0;
        model_fcs_good = valid;
    endtask

    task automatic start_trigger(input logic retx);
        @(posedge clk);
        high_trigger    <= !retx;
        retrans_trigger <= retx;
        @(posedge clk);    // trigger sampled here
        high_trigger    <= 1'b0;
        retrans_trigger <= 1'b0;
    endtask

    // counts ticks until the grant while busy gaps start and end on tick edges
    task automatic wait_grant(input logic gaps, input int ifs_ticks, output int idle_ticks,
                              output int all_ticks, output int cw_pulses);
        int busy_left;
        idle_ticks = 0;
        all_ticks  = 0;
        cw_pulses  = 0;
        busy_left  = 0;
        @(posedge clk);
        while (!backoff_done) begin
            if (us_tick) all_ticks++;
            if (us_tick && ch_idle) idle_ticks++;
            if (increase_cw) cw_pulses++;
            if (busy_left > 0) begin
                busy_left--;
                if (busy_left == 0) ch_idle <= 1'b1;
            end else if (gaps && us_tick && ch_idle && idle_ticks > ifs_ticks &&
                         next_rand() % 4 == 0) begin
                ch_idle   <= 1'b0;    // only once the backoff runs
                busy_left = 4 * (1 + next_rand() % 3);
            end
            @(posedge clk);
        end
    endtask

    task automatic release_grant();
        int hold;
        hold = 1 + next_rand() % 4;
        repeat (hold) begin
            @(posedge clk);
            check_eq("grant held", 32'(backoff_done), 1);
        end
        tx_bb_is_ongoing <= 1'b1;
        @(posedge clk);
        tx_bb_is_ongoing <= 1'b0;
        @(posedge clk);
        check_eq("grant cleared", 32'(backoff_done), 0);
    endtask

    // header, duration, addr1 and a good fcs followed by a new frame trigger
    task automatic send_frame(input logic [15:0] dur, input logic [47:0] addr);
        @(posedge clk);
        rx.hdr_strobe <= 1'b1;
        rx.hdr_valid  <= 1'b1;
        @(posedge clk);
        rx.hdr_strobe  <= 1'b0;
        rx.hdr_valid   <= 1'b0;
        rx.fc_di_valid <= 1'b1;
        rx.duration    <= dur;
        @(posedge clk);
        rx.fc_di_valid <= 1'b0;
        rx.addr1_valid <= 1'b1;
        rx.addr1       <= addr;
        @(posedge clk);
        rx.addr1_valid <= 1'b0;
        rx.fcs_strobe  <= 1'b1;
        rx.fcs_valid   <= 1'b1;
        @(posedge clk);
        rx.fcs_strobe <= 1'b0;
        high_trigger  <= 1'b1;
        @(posedge clk);    // NAV loaded and trigger sampled on this edge
        high_trigger <= 1'b0;
        model_fcs_good = 1'b1;
    endtask

    initial begin
        int          idle_t;
        int          all_t;
        int          pulses;
        int          more;
        int          cw;
        int          ifs_exp;
        int          slots;
        int          kind;
        int          dur;
        logic [31:0] a;
        logic [31:0] b;
        logic [47:0] addr;
        rng_state = 32'heb67;
        model_lfsr = LFSR_RESET;
        model_fcs_good = 1'b0;
        checks = 0;
        errors = 0;
        checks_mark = 0;
        errors_mark = 0;
        rstn = 1'b0;
        rx = '0;
        nav_enable = 1'b1;
        ifs = '0;
        cw_exp_used = 4'd0;
        ch_idle = 1'b1;
        high_trigger = 1'b0;
        retrans_trigger = 1'b0;
        tx_bb_is_ongoing = 1'b0;
        a = next_rand();
        b = next_rand();
        self_mac_addr = {a[15:0], b};
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        check_eq("backoff_done after reset", 32'(backoff_done), 0);
        check_eq("increase_cw after reset", 32'(increase_cw), 0);
        check_eq("num_slot_log after reset", 32'(num_slot_log), 0);
        end_test("reset state");

        repeat (4) begin
            new_timing();
            pulse_fcs(1'b1);
            start_trigger(1'b0);
            wait_grant(1'b0, 0, idle_t, all_t, pulses);
            check_eq("DIFS idle ticks", idle_t, model_ifs());
            release_grant();
        end
        end_test("new transmission");

        repeat (3) begin
            new_timing();
            pulse_fcs(1'b0);
            start_trigger(1'b0);
            wait_grant(1'b0, 0, idle_t, all_t, pulses);
            check_eq("EIFS idle ticks", idle_t, model_ifs());
            release_grant();
        end
        end_test("EIFS after bad fcs");

        repeat (4) begin
            new_timing();
            pulse_fcs(1'(next_rand() % 2));
            cw = next_rand() % 5;
            cw_exp_used <= 4'(cw);
            ifs_exp = model_ifs();
            start_trigger(1'b1);
            wait_grant(1'b1, ifs_exp, idle_t, all_t, pulses);
            model_lfsr = lfsr_step(model_lfsr);
            slots = slots_for(model_lfsr, cw);
            check_eq("num_slot_log", 32'(num_slot_log), slots);
            check_eq("backoff idle ticks", idle_t, ifs_exp + slots * slot_us);
            check_eq("no increase_cw on idle medium", pulses, 0);
            release_grant();
        end
        end_test("retransmission backoff");

        repeat (6) begin
            new_timing();
            kind = next_rand() % 3;    // 0 other station, 1 own address, 2 duration bit 15
            dur = 2 + next_rand() % 62;
            addr = (kind == 1) ? self_mac_addr : self_mac_addr ^ {16'h0, next_rand() | 32'h1};
            send_frame((kind == 2) ? 16'(dur) | 16'h8000 : 16'(dur), addr);
            wait_grant(1'b0, 0, idle_t, all_t, pulses);
            check_eq("ticks to grant behind NAV", all_t,
                     (kind == 0 ? dur : 0) + sifs_us + 2 * slot_us);
            release_grant();
        end
        end_test("NAV deferral");

        repeat (2) begin
            new_timing();
            pulse_fcs(1'b1);
            cw = next_rand() % 4;
            @(posedge clk);
            ch_idle         <= 1'b0;
            retrans_trigger <= 1'b1;
            cw_exp_used     <= 4'(cw);
            @(posedge clk);
            retrans_trigger <= 1'b0;
            pulses = 0;
            repeat (6 + next_rand() % 10) begin
                @(posedge clk);
                if (increase_cw) pulses++;
            end
            ch_idle <= 1'b1;
            wait_grant(1'b0, 0, idle_t, all_t, more);
            model_lfsr = lfsr_step(model_lfsr);
            check_eq("increase_cw pulses", pulses + more, 1);
            check_eq("num_slot_log", 32'(num_slot_log), slots_for(model_lfsr, cw));
            release_grant();
        end
        end_test("contention window increase");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
